// ==== all.f ====
source/ctrlPkg.sv
source/instrDecoder.sv
source/ctrlSequencer.sv
source/ctrlEncoder.sv
source/ctrlUnit.sv
test/ctrlUnit_props.sv
test/ctrlUnitTb.sv

// ==== run.sh ====
#!/bin/sh
# Build the testbench with Verilator and run it, a nonzero status means failure
verilator --binary --timing --assert -Wno-fatal -f all.f --top-module ctrlUnitTb \
    -o ctrlUnitSim \
    && ./obj_dir/ctrlUnitSim \
    || exit 1

// ==== test/ctrlUnitTb.sv ====
`timescale 1ns/1ps

module ctrlUnitTb import ctrlPkg::*; ();

    localparam int memWait = 2;
    localparam int clkPeriod = 4;
    localparam int stimDelay = 1;
    localparam int resetCycles = 8;
    localparam int traceLen = 64;
    localparam int instrCount = 48;     // Upper bound on instructions run
    localparam int cyclesPerInstr = 32; // Longest instruction is well below this

    // Bit positions in the write enable trace
    localparam int bMem = 0;
    localparam int bPc = 1;
    localparam int bIr = 2;
    localparam int bReg = 3;
    localparam int bAb = 4;
    localparam int bHilo = 5;
    localparam int bAluOut = 6;
    localparam int bEpc = 7;
    localparam int bMult = 8;
    localparam int bDiv = 9;

    logic       clk;
    logic       reset;
    opcodeT     opcode;
    functT      funct;
    logic       overflow;
    logic       equal;
    logic       greater;
    logic       multDone;
    logic       divDone;
    logic       divZero;
    logic       memWrite;
    logic       pcWrite;
    logic       irWrite;
    logic       regWrite;
    logic       abWrite;
    logic       hiloWrite;
    logic       aluOutWrite;
    logic       epcWrite;
    logic       multStart;
    logic       divStart;
    aluOpT      aluControl;
    accessSizeT storeSize;
    accessSizeT loadSize;
    logic       hiloSelect;
    regDstT     regDst;
    memToRegT   memToReg;
    pcSourceT   pcSource;
    aluSrcAT    aluSrcA;
    aluSrcBT    aluSrcB;
    addrSelT    addrSelect;

    // One entry per cycle, index 4 is stDecode1
    logic [9:0] weTr [traceLen];
    pcSourceT   pcSrcTr [traceLen];
    addrSelT    adrTr [traceLen];
    regDstT     dstTr [traceLen];
    memToRegT   wbTr [traceLen];
    aluOpT      aluTr [traceLen];
    aluSrcAT    srcATr [traceLen];
    aluSrcBT    srcBTr [traceLen];
    accessSizeT ldTr [traceLen];
    accessSizeT stTr [traceLen];
    logic       hiloSelTr [traceLen];
    int         lastIdx;
    integer     seed = 35672;

    ctrlUnit #(.memWait(memWait)) UUT (.*);

    initial begin
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk;
    end

    initial begin
        #((resetCycles + instrCount * cyclesPerInstr) * clkPeriod);
        stopWithFail("Watchdog expired before the tests finished");
    end

    task automatic endWithFail();
        $display(">>> FAIL");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic stopWithFail(input string reason);
        $display("** Error at %0t ns: %s", $time, reason);
        endWithFail();
    endtask

    task automatic checkEq(input string name, input logic [31:0] got,
                           input logic [31:0] expected);
        if (got !== expected) begin
            $display("** Error at %0t ns: %s = %0d, expected %0d", $time, name, got, expected);
            endWithFail();
        end
    endtask

    function automatic logic [9:0] currentWrites();
        return {divStart, multStart, epcWrite, aluOutWrite, hiloWrite,
                abWrite, regWrite, irWrite, pcWrite, memWrite};
    endfunction

    task automatic recordCycle(input int idx);
        weTr[idx] = currentWrites();
        pcSrcTr[idx] = pcSource;
        adrTr[idx] = addrSelect;
        dstTr[idx] = regDst;
        wbTr[idx] = memToReg;
        aluTr[idx] = aluControl;
        srcATr[idx] = aluSrcA;
        srcBTr[idx] = aluSrcB;
        ldTr[idx] = loadSize;
        stTr[idx] = storeSize;
        hiloSelTr[idx] = hiloSelect;
    endtask

    // Only the cycles of the instruction itself, not the next fetch
    function automatic int countHigh(input int bitIdx);
        int n = 0;
        for (int i = 4; i <= lastIdx - 3; i++) begin
            if (weTr[i][bitIdx])
                n++;
        end
        return n;
    endfunction

    function automatic int firstHigh(input int bitIdx);
        for (int i = 4; i <= lastIdx - 3; i++) begin
            if (weTr[i][bitIdx])
                return i;
        end
        return -1;
    endfunction

    task automatic resetDut();
        reset = 1'b1;
        @(posedge clk);
        repeat (resetCycles - 1) begin
            @(negedge clk);
            checkEq("write enables during reset", currentWrites(), 0);
            @(posedge clk);
        end
        #stimDelay;
        reset = 1'b0;
        @(negedge clk);
        checkEq("write enables in fetch1", currentWrites(), 0);
        @(negedge clk);
        checkEq("write enables in fetch2", currentWrites(), 1 << bPc);
        @(negedge clk);
        checkEq("write enables in fetch3", currentWrites(), 1 << bIr);
    endtask

    // Starts in stFetch3, records up to the irWrite of the next instruction
    task automatic runInstr(input opcodeT opc, input functT fn, input logic ovf,
                            input logic eq, input logic gt, input logic dz, input int doneAt);
        int idx;
        int len;
        @(posedge clk);
        #stimDelay;
        opcode = opc;
        funct = fn;
        overflow = ovf;
        equal = eq;
        greater = gt;
        divZero = dz;
        multDone = 1'b0;
        divDone = 1'b0;
        idx = 4;
        @(negedge clk);
        recordCycle(idx);
        while (!weTr[idx][bIr]) begin
            if (idx == traceLen - 1)
                stopWithFail("Instruction did not return to fetch");
            idx++;
            @(posedge clk);
            #stimDelay;
            if (doneAt > 0 && idx >= doneAt) begin
                multDone = 1'b1;
                divDone = 1'b1;
            end
            @(negedge clk);
            recordCycle(idx);
        end
        lastIdx = idx;
        len = lastIdx - 3;
        if (len < 6)
            stopWithFail("Instruction ended before its execute state");
        checkEq("write enables in decode1", weTr[4], 1 << bAluOut);
        checkEq("aluSrcA in decode1", srcATr[4], srcAPc);
        checkEq("aluSrcB in decode1", srcBTr[4], srcBBranchOff);
        checkEq("write enables in decode2", weTr[5], 1 << bAb);
        checkEq("write enables in end state", weTr[len], 0);
        checkEq("write enables in next fetch1", weTr[len + 1], 0);
        checkEq("write enables in next fetch2", weTr[len + 2], 1 << bPc);
        checkEq("pcSource in next fetch2", pcSrcTr[len + 2], pcAluResult);
        checkEq("aluSrcA in next fetch2", srcATr[len + 2], srcAPc);
        checkEq("aluSrcB in next fetch2", srcBTr[len + 2], srcBFour);
        checkEq("write enables in next fetch3", weTr[len + 3], 1 << bIr);
    endtask

    // First execute state reads register A and the given B operand
    task automatic checkAluInputs(input aluSrcBT srcB);
        checkEq("aluSrcA in execute", srcATr[6], srcARegA);
        checkEq("aluSrcB in execute", srcBTr[6], srcB);
    endtask

    task automatic checkRegWrite(input int idx, input regDstT dst, input memToRegT wb);
        checkEq("regWrite count", countHigh(bReg), 1);
        checkEq("regWrite cycle", firstHigh(bReg), idx);
        checkEq("regDst", dstTr[idx], dst);
        checkEq("memToReg", wbTr[idx], wb);
        checkEq("memWrite count", countHigh(bMem), 0);
        checkEq("instruction length", lastIdx - 3, idx + 1);
    endtask

    task automatic checkSinglePc(input int idx, input pcSourceT src);
        checkEq("pcWrite count", countHigh(bPc), 1);
        checkEq("pcWrite cycle", firstHigh(bPc), idx);
        checkEq("pcSource", pcSrcTr[idx], src);
    endtask

    task automatic checkException(input addrSelT vec, input int epcIdx);
        checkEq("epcWrite cycle", firstHigh(bEpc), epcIdx);
        for (int k = 1; k <= memWait + 1; k++)
            checkEq("addrSelect in vector fetch", adrTr[epcIdx + k], vec);
        checkSinglePc(epcIdx + memWait + 2, pcExcVector);
        checkEq("loadSize on vector load", ldTr[epcIdx + memWait + 2], szByte);
        checkEq("regWrite count", countHigh(bReg), 0);
        checkEq("instruction length", lastIdx - 3, epcIdx + memWait + 3);
    endtask

    task automatic testAluOps();
        functT fns[3];
        aluOpT ops[3];
        fns = '{fnAdd, fnSub, fnAnd};
        ops = '{aluAdd, aluSub, aluAnd};
        for (int k = 0; k < 3; k++) begin
            runInstr(opcRType, fns[k], 1'b0, 1'b0, 1'b0, 1'b0, 0);
            checkEq("aluControl in R-type execute", aluTr[6], ops[k]);
            checkAluInputs(srcBRegB);
            checkRegWrite(7, dstRd, wbAluOut);
        end
        runInstr(opcRType, fnSlt, 1'b0, 1'b0, 1'b0, 1'b0, 0);
        checkEq("aluControl in SLT", aluTr[6], aluCompare);
        checkAluInputs(srcBRegB);
        checkRegWrite(6, dstRd, wbLessThan);
        runInstr(opcSlti, 6'h00, 1'b0, 1'b0, 1'b0, 1'b0, 0);
        checkEq("aluControl in SLTI", aluTr[6], aluCompare);
        checkAluInputs(srcBSignImm);
        checkRegWrite(6, dstRt, wbLessThan);
        runInstr(opcAddi, 6'h00, 1'b0, 1'b0, 1'b0, 1'b0, 0);
        checkEq("aluControl in ADDI", aluTr[6], aluAdd);
        checkAluInputs(srcBSignImm);
        checkRegWrite(7, dstRt, wbAluOut);
        runInstr(opcAddiu, 6'h00, 1'b1, 1'b0, 1'b0, 1'b0, 0); // Unsigned ignores overflow
        checkEq("aluControl in ADDIU", aluTr[6], aluAdd);
        checkAluInputs(srcBSignImm);
        checkRegWrite(7, dstRt, wbAluOut);
        runInstr(opcAddi, 6'h00, 1'b1, 1'b0, 1'b0, 1'b0, 0);
        checkException(adrVecOverflow, 7);
    endtask

    task automatic testMemory();
        opcodeT     loadOps[3];
        opcodeT     storeOps[3];
        accessSizeT sizes[3];
        int         accessIdx;
        loadOps = '{opcLw, opcLh, opcLb};
        storeOps = '{opcSw, opcSh, opcSb};
        sizes = '{szWord, szHalf, szByte};
        accessIdx = 6 + memWait + 1; // Execute state is cycle 6
        for (int k = 0; k < 3; k++) begin
            runInstr(loadOps[k], 6'h00, 1'b0, 1'b0, 1'b0, 1'b0, 0);
            checkAluInputs(srcBSignImm);
            checkRegWrite(accessIdx, dstRt, wbMemory);
            checkEq("loadSize", ldTr[accessIdx], sizes[k]);
            runInstr(storeOps[k], 6'h00, 1'b0, 1'b0, 1'b0, 1'b0, 0);
            checkAluInputs(srcBSignImm);
            for (int c = 7; c < accessIdx; c++)
                checkEq("addrSelect in store wait", adrTr[c], adrAluOut);
            checkEq("memWrite count", countHigh(bMem), 1);
            checkEq("memWrite cycle", firstHigh(bMem), accessIdx);
            checkEq("storeSize", stTr[accessIdx], sizes[k]);
            checkEq("regWrite count in store", countHigh(bReg), 0);
            checkEq("store length", lastIdx - 3, accessIdx + 1);
        end
    endtask

    task automatic testBranches();
        opcodeT      brOps[4];
        logic [31:0] r;
        int          pick;
        logic        eq;
        logic        gt;
        logic        taken;
        brOps = '{opcBeq, opcBne, opcBle, opcBgt};
        repeat (16) begin
            r = $random(seed);
            pick = r[1:0];
            eq = r[4];
            gt = r[7];
            case (pick)
                0: taken = eq;
                1: taken = !eq;
                2: taken = !gt;
                default: taken = gt;
            endcase
            runInstr(brOps[pick], 6'h00, 1'b0, eq, gt, 1'b0, 0);
            checkAluInputs(srcBRegB);
            checkEq("pcWrite count in branch", countHigh(bPc), taken);
            if (taken) begin
                checkEq("taken branch pcWrite cycle", firstHigh(bPc), 7);
                checkEq("pcSource in taken branch", pcSrcTr[7], pcAluOut);
            end
            checkEq("branch length", lastIdx - 3, taken ? 8 : 7);
        end
    endtask

    task automatic testMulDiv();
        logic [31:0] r;
        int          doneAt;
        int          startBit;
        logic        isDiv;
        for (int k = 0; k < 6; k++) begin
            r = $random(seed);
            doneAt = 7 + 1 + ($unsigned(r) % 6);
            isDiv = k[0];
            startBit = isDiv ? bDiv : bMult;
            runInstr(opcRType, isDiv ? fnDiv : fnMult, 1'b0, 1'b0, 1'b0, 1'b0, doneAt);
            checkEq("start level cycles", countHigh(startBit), doneAt - 5);
            checkEq("start level first cycle", firstHigh(startBit), 6);
            checkEq("other unit start", countHigh(isDiv ? bMult : bDiv), 0);
            checkEq("hiloWrite count", countHigh(bHilo), 1);
            checkEq("hiloWrite cycle", firstHigh(bHilo), doneAt + 1);
            checkEq("hiloSelect", hiloSelTr[doneAt + 1], isDiv);
            checkEq("multiply or divide length", lastIdx - 3, doneAt + 2);
        end
        // divZero arrives with divDone and still wins
        runInstr(opcRType, fnDiv, 1'b0, 1'b0, 1'b0, 1'b1, 7);
        checkException(adrVecDivZero, 8);
        checkEq("hiloWrite count on divide by zero", countHigh(bHilo), 0);
    endtask

    task automatic testJumps();
        runInstr(opcJ, 6'h00, 1'b0, 1'b0, 1'b0, 1'b0, 0);
        checkSinglePc(6, pcJumpTarget);
        checkEq("regWrite count in J", countHigh(bReg), 0);
        checkEq("J length", lastIdx - 3, 7);
        runInstr(opcJal, 6'h00, 1'b0, 1'b0, 1'b0, 1'b0, 0);
        checkSinglePc(7, pcJumpTarget);
        checkRegWrite(7, dstRa, wbAluOut);
        runInstr(opcRType, fnJr, 1'b0, 1'b0, 1'b0, 1'b0, 0);
        checkSinglePc(6, pcAluResult);
        checkEq("regWrite count in JR", countHigh(bReg), 0);
        checkEq("JR length", lastIdx - 3, 7);
        runInstr(6'h3F, 6'h00, 1'b0, 1'b0, 1'b0, 1'b0, 0); // Unused opcode
        checkException(adrVecOpcode, 6);
        runInstr(opcRType, 6'h3F, 1'b0, 1'b0, 1'b0, 1'b0, 0); // Unused funct
        checkException(adrVecOpcode, 6);
    endtask

    initial begin
        reset = 1'b1;
        opcode = opcRType;
        funct = fnAdd;
        overflow = 1'b0;
        equal = 1'b0;
        greater = 1'b0;
        multDone = 1'b0;
        divDone = 1'b0;
        divZero = 1'b0;
        resetDut();
        testAluOps();
        testMemory();
        testBranches();
        testMulDiv();
        testJumps();
        $display(">>> PASS");
        $finish;
    end

endmodule

// ==== test/ctrlUnit_props.sv ====
`timescale 1ns/1ps

module ctrlUnitProps (
    input logic clk,
    input logic reset,
    input logic memWrite,
    input logic pcWrite,
    input logic irWrite,
    input logic regWrite,
    input logic abWrite,
    input logic hiloWrite,
    input logic aluOutWrite,
    input logic epcWrite,
    input logic multDone,
    input logic divDone
);

    logic anyWrite;

    assign anyWrite = memWrite | pcWrite | irWrite | regWrite | abWrite |
                      hiloWrite | aluOutWrite | epcWrite;

    memRegExclusive: assert property (@(posedge clk) !(memWrite && regWrite))
        else $error("memWrite and regWrite high in the same cycle");

    pcWriteSingle: assert property (@(posedge clk) disable iff (reset) pcWrite |=> !pcWrite)
        else $error("pcWrite held for more than one cycle");

    // HI/LO is written only once an arithmetic unit reported done
    hiloAfterDone: assert property (@(posedge clk) disable iff (reset)
        hiloWrite |-> $past(multDone || divDone))
        else $error("hiloWrite without a done flag in the cycle before");

    quietAfterReset: assert property (@(posedge clk) $past(reset) |-> !anyWrite)
        else $error("Write enable high in the cycle after reset");

endmodule

bind ctrlUnit ctrlUnitProps props (.*);

// ==== source/ctrlUnit.sv ====
`timescale 1ns/1ps

module ctrlUnit import ctrlPkg::*; #(
    parameter int memWait = 2
) (
    input  logic       clk,
    input  logic       reset,
    input  opcodeT     opcode,
    input  functT      funct,
    input  logic       overflow,
    input  logic       equal,
    input  logic       greater,
    input  logic       multDone,
    input  logic       divDone,
    input  logic       divZero,
    output logic       memWrite,
    output logic       pcWrite,
    output logic       irWrite,
    output logic       regWrite,
    output logic       abWrite,
    output logic       hiloWrite,
    output logic       aluOutWrite,
    output logic       epcWrite,
    output logic       multStart,
    output logic       divStart,
    output aluOpT      aluControl,
    output accessSizeT storeSize,
    output accessSizeT loadSize,
    output logic       hiloSelect,
    output regDstT     regDst,
    output memToRegT   memToReg,
    output pcSourceT   pcSource,
    output aluSrcAT    aluSrcA,
    output aluSrcBT    aluSrcB,
    output addrSelT    addrSelect
);

    instrClassT instrClass;
    aluOpT      aluOp;
    accessSizeT accessSize;
    ctrlStateT  state;
    excKindT    excKind;

    instrDecoder decoder (.*);

    ctrlSequencer #(.memWait(memWait)) sequencer (.*);

    ctrlEncoder encoder (.*); // Moore outputs from state alone

endmodule

// ==== source/ctrlEncoder.sv ====
`timescale 1ns/1ps

module ctrlEncoder import ctrlPkg::*; (
    input  ctrlStateT  state,
    input  aluOpT      aluOp,
    input  accessSizeT accessSize,
    input  excKindT    excKind,
    output logic       memWrite,
    output logic       pcWrite,
    output logic       irWrite,
    output logic       regWrite,
    output logic       abWrite,
    output logic       hiloWrite,
    output logic       aluOutWrite,
    output logic       epcWrite,
    output logic       multStart,
    output logic       divStart,
    output aluOpT      aluControl,
    output accessSizeT storeSize,
    output accessSizeT loadSize,
    output logic       hiloSelect,
    output regDstT     regDst,
    output memToRegT   memToReg,
    output pcSourceT   pcSource,
    output aluSrcAT    aluSrcA,
    output aluSrcBT    aluSrcB,
    output addrSelT    addrSelect
);

    always_comb begin
        // Idle values, which are also what stEnd drives
        memWrite = 1'b0;
        pcWrite = 1'b0;
        irWrite = 1'b0;
        regWrite = 1'b0;
        abWrite = 1'b0;
        hiloWrite = 1'b0;
        aluOutWrite = 1'b0;
        epcWrite = 1'b0;
        multStart = 1'b0;
        divStart = 1'b0;
        aluControl = aluPassA;
        storeSize = szNone;
        loadSize = szNone;
        hiloSelect = 1'b0;
        regDst = dstRt;
        memToReg = wbAluOut;
        pcSource = pcExcVector;
        aluSrcA = srcAPc;
        aluSrcB = srcBRegB;
        addrSelect = adrPc;

        case (state)
            stFetch1: begin // Read at PC, PC+4 on the ALU
                aluSrcB = srcBFour;
                aluControl = aluAdd;
            end
            stFetch2: begin
                aluSrcB = srcBFour;
                aluControl = aluAdd;
                pcSource = pcAluResult;
                pcWrite = 1'b1;
            end
            stFetch3: irWrite = 1'b1;
            stDecode1: begin // Branch target into aluOut
                aluSrcB = srcBBranchOff;
                aluControl = aluAdd;
                aluOutWrite = 1'b1;
            end
            stDecode2: abWrite = 1'b1;
            stExAluR: begin
                aluSrcA = srcARegA;
                aluControl = aluOp;
                aluOutWrite = 1'b1;
            end
            stWbRd: begin
                regDst = dstRd;
                regWrite = 1'b1;
            end
            stExAluI: begin
                aluSrcA = srcARegA;
                aluSrcB = srcBSignImm;
                aluControl = aluOp;
                aluOutWrite = 1'b1;
            end
            stWbRt: regWrite = 1'b1;
            stExSlt: begin
                aluSrcA = srcARegA;
                aluControl = aluCompare;
                regDst = dstRd;
                memToReg = wbLessThan;
                regWrite = 1'b1;
            end
            stExSlti: begin
                aluSrcA = srcARegA;
                aluSrcB = srcBSignImm;
                aluControl = aluCompare;
                memToReg = wbLessThan;
                regWrite = 1'b1;
            end
            stExLoad, stExStore: begin // Effective address
                aluSrcA = srcARegA;
                aluSrcB = srcBSignImm;
                aluControl = aluAdd;
                aluOutWrite = 1'b1;
                addrSelect = adrAluResult;
            end
            stLoadWait, stStoreWait: addrSelect = adrAluOut;
            stLoadWb: begin
                addrSelect = adrAluOut;
                memToReg = wbMemory;
                loadSize = accessSize;
                regWrite = 1'b1;
            end
            stStoreWr: begin
                addrSelect = adrAluOut;
                storeSize = accessSize;
                memWrite = 1'b1;
            end
            stExBranch: begin // Sets equal and greater
                aluSrcA = srcARegA;
                aluControl = aluCompare;
            end
            stBranchTake: begin
                pcSource = pcAluOut;
                pcWrite = 1'b1;
            end
            stExJump: begin
                pcSource = pcJumpTarget;
                pcWrite = 1'b1;
            end
            stExJal: aluOutWrite = 1'b1; // Return address through the ALU
            stJalJump: begin
                pcSource = pcJumpTarget;
                pcWrite = 1'b1;
                regDst = dstRa;
                regWrite = 1'b1;
            end
            stExJr: begin
                aluSrcA = srcARegA;
                pcSource = pcAluResult;
                pcWrite = 1'b1;
            end
            stExMult, stMultWait: multStart = 1'b1;
            stMultDone: hiloWrite = 1'b1;
            stExDiv, stDivWait: divStart = 1'b1;
            stDivDone: begin
                hiloSelect = 1'b1;
                hiloWrite = 1'b1;
            end
            stExcEpc: begin // EPC gets PC-4
                aluSrcB = srcBFour;
                aluControl = aluSub;
                epcWrite = 1'b1;
            end
            stExcVector, stExcLoadPc: begin
                case (excKind)
                    excOverflow: addrSelect = adrVecOverflow;
                    excDivZero:  addrSelect = adrVecDivZero;
                    default:     addrSelect = adrVecOpcode;
                endcase
                if (state == stExcLoadPc) begin
                    pcSource = pcExcVector;
                    loadSize = szByte; // Handler address is one byte
                    pcWrite = 1'b1;
                end
            end
            default: ;
        endcase
    end

endmodule

// ==== source/ctrlSequencer.sv ====
`timescale 1ns/1ps

module ctrlSequencer import ctrlPkg::*; #(
    parameter int memWait = 2
) (
    input  logic       clk,
    input  logic       reset,
    input  instrClassT instrClass,
    input  logic       overflow,
    input  logic       equal,
    input  logic       greater,
    input  logic       multDone,
    input  logic       divDone,
    input  logic       divZero,
    output ctrlStateT  state,
    output excKindT    excKind
);

    localparam int cntWidth = $clog2(memWait + 2);
    // Memory waits last memWait cycles, the vector fetch one more
    localparam logic [cntWidth-1:0] memWaitLast =
        (memWait > 0) ? cntWidth'(memWait - 1) : '0;
    localparam logic [cntWidth-1:0] vecWaitLast = cntWidth'(memWait);

    ctrlStateT           nextState;
    excKindT             excCause;
    logic [cntWidth-1:0] waitCnt;
    logic                waitDone;
    logic                branchTaken;

    assign waitDone = (waitCnt == '0);

    always_comb begin
        case (instrClass)
            clsBeq:  branchTaken = equal;
            clsBne:  branchTaken = !equal;
            clsBgt:  branchTaken = greater;
            clsBle:  branchTaken = !greater;
            default: branchTaken = 1'b0;
        endcase
    end

    always_comb begin
        nextState = state; // Wait states stall here
        excCause = excKind;
        case (state)
            stFetch1:  nextState = stFetch2;
            stFetch2:  nextState = stFetch3;
            stFetch3:  nextState = stDecode1;
            stDecode1: nextState = stDecode2;
            stDecode2: begin
                case (instrClass)
                    clsAluR:                        nextState = stExAluR;
                    clsSlt:                         nextState = stExSlt;
                    clsAddi, clsAddiu:              nextState = stExAluI;
                    clsSlti:                        nextState = stExSlti;
                    clsLoad:                        nextState = stExLoad;
                    clsStore:                       nextState = stExStore;
                    clsBeq, clsBne, clsBle, clsBgt: nextState = stExBranch;
                    clsJ:                           nextState = stExJump;
                    clsJal:                         nextState = stExJal;
                    clsJr:                          nextState = stExJr;
                    clsMult:                        nextState = stExMult;
                    clsDiv:                         nextState = stExDiv;
                    default: begin
                        nextState = stExcEpc;
                        excCause = excOpcode;
                    end
                endcase
            end
            stExAluR: nextState = stWbRd;
            stWbRd:   nextState = stEnd;
            // Overflow is decided while the add is on the ALU, before rt is written
            stExAluI: begin
                if (instrClass == clsAddi && overflow) begin
                    nextState = stExcEpc;
                    excCause = excOverflow;
                end else begin
                    nextState = stWbRt;
                end
            end
            stWbRt:      nextState = stEnd;
            stExSlt:     nextState = stEnd;
            stExSlti:    nextState = stEnd;
            stExLoad:    nextState = (memWait == 0) ? stLoadWb : stLoadWait;
            stLoadWait:  if (waitDone) nextState = stLoadWb;
            stLoadWb:    nextState = stEnd;
            stExStore:   nextState = (memWait == 0) ? stStoreWr : stStoreWait;
            stStoreWait: if (waitDone) nextState = stStoreWr;
            stStoreWr:   nextState = stEnd;
            stExBranch:  nextState = branchTaken ? stBranchTake : stEnd;
            stBranchTake: nextState = stEnd;
            stExJump:    nextState = stEnd;
            stExJal:     nextState = stJalJump;
            stJalJump:   nextState = stEnd;
            stExJr:      nextState = stEnd;
            stExMult:    nextState = stMultWait;
            stMultWait:  if (multDone) nextState = stMultDone;
            stMultDone:  nextState = stEnd;
            stExDiv:     nextState = stDivWait;
            stDivWait: begin
                if (divZero) begin // Wins over divDone
                    nextState = stExcEpc;
                    excCause = excDivZero;
                end else if (divDone) begin
                    nextState = stDivDone;
                end
            end
            stDivDone:   nextState = stEnd;
            stExcEpc:    nextState = stExcVector;
            stExcVector: if (waitDone) nextState = stExcLoadPc;
            stExcLoadPc: nextState = stEnd;
            stEnd:       nextState = stFetch1;
            default:     nextState = stFetch1;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= stFetch1;
            excKind <= excOpcode;
            waitCnt <= '0;
        end else begin
            state <= nextState;
            excKind <= excCause;
            case (state)
                stExLoad, stExStore: waitCnt <= memWaitLast;
                stExcEpc:            waitCnt <= vecWaitLast;
                stLoadWait, stStoreWait, stExcVector: waitCnt <= waitCnt - 1'b1;
                default:             waitCnt <= waitCnt;
            endcase
        end
    end

endmodule

// ==== source/instrDecoder.sv ====
`timescale 1ns/1ps

module instrDecoder import ctrlPkg::*; (
    input  opcodeT     opcode,
    input  functT      funct,
    output instrClassT instrClass,
    output aluOpT      aluOp,
    output accessSizeT accessSize
);

    always_comb begin
        instrClass = clsIllegal; // Anything unlisted traps
        case (opcode)
            opcRType: begin
                case (funct)
                    fnAdd, fnSub, fnAnd: instrClass = clsAluR;
                    fnSlt:               instrClass = clsSlt;
                    fnJr:                instrClass = clsJr;
                    fnMult:              instrClass = clsMult;
                    fnDiv:               instrClass = clsDiv;
                    default:             instrClass = clsIllegal;
                endcase
            end
            opcAddi:             instrClass = clsAddi;
            opcAddiu:            instrClass = clsAddiu;
            opcSlti:             instrClass = clsSlti;
            opcLw, opcLh, opcLb: instrClass = clsLoad;
            opcSw, opcSh, opcSb: instrClass = clsStore;
            opcBeq:              instrClass = clsBeq;
            opcBne:              instrClass = clsBne;
            opcBle:              instrClass = clsBle;
            opcBgt:              instrClass = clsBgt;
            opcJ:                instrClass = clsJ;
            opcJal:              instrClass = clsJal;
            default:             instrClass = clsIllegal;
        endcase
    end

    // Only R-type looks at funct
    always_comb begin
        aluOp = aluAdd;
        case (opcode)
            opcRType: begin
                case (funct)
                    fnSub:   aluOp = aluSub;
                    fnAnd:   aluOp = aluAnd;
                    fnSlt:   aluOp = aluCompare;
                    default: aluOp = aluAdd;
                endcase
            end
            opcSlti, opcBeq, opcBne, opcBle, opcBgt: aluOp = aluCompare;
            default: aluOp = aluAdd; // ADDI, ADDIU and address math
        endcase
    end

    always_comb begin
        case (opcode)
            opcLw, opcSw: accessSize = szWord;
            opcLh, opcSh: accessSize = szHalf;
            opcLb, opcSb: accessSize = szByte;
            default:      accessSize = szNone;
        endcase
    end

endmodule

// ==== source/ctrlPkg.sv ====
package ctrlPkg;

    typedef logic [5:0] opcodeT;
    typedef logic [5:0] functT;

    // Opcodes
    localparam opcodeT opcRType = 6'h00;
    localparam opcodeT opcJ     = 6'h02;
    localparam opcodeT opcJal   = 6'h03;
    localparam opcodeT opcBeq   = 6'h04;
    localparam opcodeT opcBne   = 6'h05;
    localparam opcodeT opcBle   = 6'h06;
    localparam opcodeT opcBgt   = 6'h07;
    localparam opcodeT opcAddi  = 6'h08;
    localparam opcodeT opcAddiu = 6'h09;
    localparam opcodeT opcSlti  = 6'h0A;
    localparam opcodeT opcLw    = 6'h0F;
    localparam opcodeT opcLb    = 6'h20;
    localparam opcodeT opcLh    = 6'h21;
    localparam opcodeT opcSb    = 6'h28;
    localparam opcodeT opcSh    = 6'h29;
    localparam opcodeT opcSw    = 6'h2B;

    // R-type funct codes
    localparam functT fnJr   = 6'h08;
    localparam functT fnMult = 6'h18;
    localparam functT fnDiv  = 6'h1A;
    localparam functT fnAdd  = 6'h20;
    localparam functT fnSub  = 6'h22;
    localparam functT fnAnd  = 6'h24;
    localparam functT fnSlt  = 6'h2A;

    // 17 classes, one more than 4 bits can hold
    typedef enum logic [4:0] {
        clsAluR, clsSlt, clsAddi, clsAddiu, clsSlti,
        clsLoad, clsStore,
        clsBeq, clsBne, clsBle, clsBgt,
        clsJ, clsJal, clsJr,
        clsMult, clsDiv,
        clsIllegal
    } instrClassT;

    // 33 states
    typedef enum logic [5:0] {
        stFetch1, stFetch2, stFetch3, stDecode1, stDecode2,
        stExAluR, stWbRd, stExAluI, stWbRt, stExSlt, stExSlti,
        stExLoad, stLoadWait, stLoadWb,
        stExStore, stStoreWait, stStoreWr,
        stExBranch, stBranchTake,
        stExJump, stExJal, stJalJump, stExJr,
        stExMult, stMultWait, stMultDone, stExDiv, stDivWait, stDivDone,
        stExcEpc, stExcVector, stExcLoadPc, stEnd
    } ctrlStateT;

    typedef enum logic [2:0] {
        aluPassA   = 3'd0,
        aluAdd     = 3'd1,
        aluSub     = 3'd2,
        aluAnd     = 3'd3,
        aluCompare = 3'd7
    } aluOpT;

    typedef enum logic [1:0] {szNone, szWord, szHalf, szByte} accessSizeT;

    typedef enum logic [2:0] {
        pcExcVector  = 3'd0,
        pcAluResult  = 3'd1,
        pcAluOut     = 3'd2,
        pcJumpTarget = 3'd3
    } pcSourceT;

    typedef enum logic [2:0] {
        adrPc          = 3'd0,
        adrAluResult   = 3'd1,
        adrAluOut      = 3'd2,
        adrVecOpcode   = 3'd3,
        adrVecOverflow = 3'd4,
        adrVecDivZero  = 3'd5
    } addrSelT;

    typedef enum logic [1:0] {dstRt, dstRd, dstRa} regDstT;
    typedef enum logic [1:0] {wbAluOut, wbLessThan, wbMemory} memToRegT;
    typedef enum logic {srcAPc, srcARegA} aluSrcAT;
    typedef enum logic [1:0] {srcBRegB, srcBFour, srcBSignImm, srcBBranchOff} aluSrcBT;
    typedef enum logic [1:0] {excOpcode, excOverflow, excDivZero} excKindT;

endpackage
